/* Bender.yml */
package:
  name: rvCore

sources:
  - include_dirs:
      - .
    files:
      - rvPkg.sv
      - rvAlu.sv
      - rvRegFile.sv
      - rvDecode.sv
      - rvHazard.sv
      - rvFetch.sv
      - rvCore.sv
  - target: test
    include_dirs:
      - .
    files:
      - rvCoreTbMem.sv
      - rvCoreTb.sv

/* compile.f */
+incdir+.
rvPkg.sv
rvAlu.sv
rvRegFile.sv
rvDecode.sv
rvHazard.sv
rvFetch.sv
rvCore.sv
rvCoreTbMem.sv
rvCoreTb.sv

/* rvAlu.sv */
// Execute stage ALU

`default_nettype none

`include "rvConsts.svh"

module rvAlu
	import rvPkg::*;
(
	input  wire logic [`XLEN-1:0]  inA,
	input  wire logic [`XLEN-1:0]  inB,
	input  wire aluOpT             op,
	output logic [`XLEN-1:0]       result
);

	localparam int SHAMT_W = $clog2(`XLEN);

	logic [SHAMT_W-1:0] shamt;
	logic lessThan;

	assign shamt = inB[SHAMT_W-1:0];
	assign lessThan = $signed(inA) < $signed(inB);

	always_comb begin
		case (op)
			AluAdd:  result = inA + inB;
			AluSub:  result = inA - inB;
			AluSll:  result = inA << shamt;
			AluSlt:  result = {{(`XLEN-1){1'b0}}, lessThan};
			AluXor:  result = inA ^ inB;
			AluSrl:  result = inA >> shamt;
			AluSra:  result = $signed(inA) >>> shamt; // Sign fill
			AluOr:   result = inA | inB;
			AluAnd:  result = inA & inB;
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

/* rvConsts.svh */
// RV32I core constants

`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// ==========================================================================
// Datapath widths
// ==========================================================================

// Data and address width
`define XLEN 32

// Register index width and register count
`define REG_ADDR_W 5
`define NUM_REGS 32

// ==========================================================================
// Fixed encodings
// ==========================================================================

// addi x0, x0, 0
`define NOP_INST 32'h0000_0013

// First fetch address
`define RESET_PC 32'h0000_0000

`endif

/* rvCore.sv */
// Five-stage RV32I pipeline

`default_nettype none

`include "rvConsts.svh"

module rvCore
	import rvPkg::*;
(
	input  wire logic                clk,
	input  wire logic                rst_n,
	output logic [`XLEN-3:0]         imemAddr,
	input  wire logic [`XLEN-1:0]    imemData,
	input  wire logic                imemStall,
	output logic                     dmemRead,
	output logic                     dmemWrite,
	output logic [`XLEN-3:0]         dmemAddr,
	output logic [`XLEN-1:0]         dmemWdata,
	input  wire logic [`XLEN-1:0]    dmemRdata,
	input  wire logic                dmemStall
);

	localparam logic [`XLEN-1:0] PC_STEP = 4;

	// ID stage
	logic [`XLEN-1:0] idPc, idInst, idImm, idRs1Data, idRs2Data, branchRs1, branchRs2;
	logic [`REG_ADDR_W-1:0] idRs1, idRs2, idRd;
	logic isJal, isJalr, isBeq, isBne;
	logic idMemRead, idMemWrite, idMemToReg, idAluSrc, idRegWrite;
	aluOpT idAluOp;
	logic memStall, hazardStall, flushIfId, branchTaken;

	// EX stage
	logic [`XLEN-1:0] exPc4, exRs1Data, exRs2Data, exImm, exOpA, exOpB, aluInB, aluResult;
	logic [`REG_ADDR_W-1:0] exRs1, exRs2, exRd;
	aluOpT exAluOp;
	logic exAluSrc, exMemRead, exMemWrite, exMemToReg, exRegWrite, exIsJump;
	fwdSelT fwdA, fwdB;

	// MEM and WB stages
	logic [`XLEN-1:0] memPc4, memAlu, memWdata, memResult, wbData;
	logic [`REG_ADDR_W-1:0] memRd, wbRd;
	logic memMemRead, memMemWrite, memMemToReg, memRegWrite, memIsJump, wbRegWrite;

	function automatic logic [`XLEN-1:0] pickOperand(input fwdSelT sel,
			input logic [`XLEN-1:0] regValue);
		case (sel)
			FwdMem:  pickOperand = memResult;
			FwdWb:   pickOperand = wbData;
			default: pickOperand = regValue;
		endcase
	endfunction

	assign memStall = imemStall || dmemStall; // Freezes every stage

	rvFetch fetch_inst (
		.clk(clk), .rst_n(rst_n), .memStall(memStall), .hazardStall(hazardStall),
		.flushIfId(flushIfId), .imemData(imemData), .isJal(isJal), .isJalr(isJalr),
		.isBeq(isBeq), .isBne(isBne), .immediate(idImm), .branchRs1(branchRs1),
		.branchRs2(branchRs2), .imemAddr(imemAddr), .idPc(idPc), .idInst(idInst),
		.branchTaken(branchTaken)
	);

	rvDecode decode_inst (
		.inst(idInst), .isJal(isJal), .isJalr(isJalr), .isBeq(isBeq), .isBne(isBne),
		.memRead(idMemRead), .memWrite(idMemWrite), .memToReg(idMemToReg),
		.aluSrc(idAluSrc), .regWrite(idRegWrite), .aluOp(idAluOp), .immediate(idImm),
		.rs1(idRs1), .rs2(idRs2), .rd(idRd)
	);

	rvRegFile regFile_inst (
		.clk(clk), .rst_n(rst_n), .rs1(idRs1), .rs2(idRs2), .wrAddr(wbRd),
		.wrData(wbData), .wrEn(wbRegWrite), .rs1Data(idRs1Data), .rs2Data(idRs2Data)
	);

	rvHazard hazard_inst (
		.idRs1(idRs1), .idRs2(idRs2), .idIsJalr(isJalr), .idIsBranch(isBeq || isBne),
		.branchTaken(branchTaken), .idIsJal(isJal), .idRs1Data(idRs1Data),
		.idRs2Data(idRs2Data), .exRd(exRd), .exMemRead(exMemRead), .exRegWrite(exRegWrite),
		.exRs1(exRs1), .exRs2(exRs2), .memRd(memRd), .memRegWrite(memRegWrite),
		.memResult(memResult), .wbRd(wbRd), .wbRegWrite(wbRegWrite), .wbData(wbData),
		.hazardStall(hazardStall), .flushIfId(flushIfId), .fwdA(fwdA), .fwdB(fwdB),
		.branchRs1(branchRs1), .branchRs2(branchRs2)
	);

	// ==========================================================================
	// ID/EX
	// ==========================================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exMemRead <= 1'b0;
			exMemWrite <= 1'b0;
			exMemToReg <= 1'b0;
			exRegWrite <= 1'b0;
			exIsJump <= 1'b0;
		end else if (!memStall) begin // Bubble on hazard stall
			exMemRead <= idMemRead && !hazardStall;
			exMemWrite <= idMemWrite && !hazardStall;
			exMemToReg <= idMemToReg;
			exRegWrite <= idRegWrite && !hazardStall;
			exIsJump <= (isJal || isJalr) && !hazardStall;
		end
	end

	always_ff @(posedge clk) begin
		if (!memStall) begin
			exPc4 <= idPc + PC_STEP; // Link value
			exRs1Data <= idRs1Data;
			exRs2Data <= idRs2Data;
			exImm <= idImm;
			exRs1 <= idRs1;
			exRs2 <= idRs2;
			exRd <= idRd;
			exAluOp <= idAluOp;
			exAluSrc <= idAluSrc;
		end
	end

	// Execute
	assign exOpA = pickOperand(fwdA, exRs1Data);
	assign exOpB = pickOperand(fwdB, exRs2Data); // Also the store data
	assign aluInB = exAluSrc ? exImm : exOpB;

	rvAlu alu_inst (.inA(exOpA), .inB(aluInB), .op(exAluOp), .result(aluResult));

	// ==========================================================================
	// EX/MEM
	// ==========================================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			memMemRead <= 1'b0;
			memMemWrite <= 1'b0;
			memMemToReg <= 1'b0;
			memRegWrite <= 1'b0;
			memIsJump <= 1'b0;
		end else if (!memStall) begin
			memMemRead <= exMemRead;
			memMemWrite <= exMemWrite;
			memMemToReg <= exMemToReg;
			memRegWrite <= exRegWrite;
			memIsJump <= exIsJump;
		end
	end

	always_ff @(posedge clk) begin
		if (!memStall) begin
			memPc4 <= exPc4;
			memAlu <= aluResult;
			memWdata <= exOpB;
			memRd <= exRd;
		end
	end

	// Data port straight from EX/MEM
	assign dmemRead = memMemRead;
	assign dmemWrite = memMemWrite;
	assign dmemAddr = memAlu[`XLEN-1:2];
	assign dmemWdata = memWdata;

	// Write-back value, selected one stage early so MEM can forward it
	always_comb begin
		if (memIsJump) memResult = memPc4;
		else if (memMemToReg) memResult = dmemRdata;
		else memResult = memAlu;
	end

	// ==========================================================================
	// MEM/WB
	// ==========================================================================
	always_ff @(posedge clk) begin
		if (!rst_n) wbRegWrite <= 1'b0;
		else if (!memStall) wbRegWrite <= memRegWrite;
	end

	always_ff @(posedge clk) begin
		if (!memStall) begin
			wbRd <= memRd;
			wbData <= memResult;
		end
	end

	dmemStrobesExclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(dmemRead && dmemWrite));

endmodule

`default_nettype wire

/* rvCoreTb.sv */
// RV32I pipeline testbench

`default_nettype none

`include "rvConsts.svh"

module rvCoreTb;

	localparam int NUM_STORES = 18;
	localparam int PROG_LEN = 56;
	localparam int WATCHDOG_CYCLES = PROG_LEN * 72; // Worst-case stall rate with margin
	localparam logic [`XLEN-1:0] RESET_PC_VAL = `RESET_PC;

	// Expected stores, word address and value, in program order
	localparam logic [29:0] EXP_ADDR [NUM_STORES] = '{
		30'd0, 30'd1, 30'd2, 30'd3, 30'd4, 30'd5, 30'd6, 30'd7, 30'd8,
		30'd9, 30'd10, 30'd11, 30'd12, 30'd13, 30'd14, 30'd15, 30'd16, 30'd17
	};
	localparam logic [31:0] EXP_DATA [NUM_STORES] = '{
		32'h0000_005D, 32'h0000_006B, 32'h0000_0320, 32'h0000_0001,
		32'hFFFF_FF9D, 32'h1FFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFD,
		32'h0000_0060, 32'h0000_0141, 32'hFFFF_FFFC,
		32'hC0DE_0107, 32'h0000_00C1,
		32'h0000_0003, 32'h0000_0003, 32'h0000_00B4, 32'h0000_00C4, 32'h0000_0003
	};

	logic clk;
	logic rst_n;
	logic [`XLEN-3:0] imemAddr, dmemAddr;
	logic [`XLEN-1:0] imemData, dmemWdata, dmemRdata;
	logic imemStall, dmemStall, dmemRead, dmemWrite;
	logic storeAccepted, stallQ, inResetQ;
	logic [3*`XLEN-3:0] portQ;
	int storeIdx;
	int failCount;

	rvCore rvCore_inst (
		.clk(clk), .rst_n(rst_n), .imemAddr(imemAddr), .imemData(imemData),
		.imemStall(imemStall), .dmemRead(dmemRead), .dmemWrite(dmemWrite),
		.dmemAddr(dmemAddr), .dmemWdata(dmemWdata), .dmemRdata(dmemRdata),
		.dmemStall(dmemStall)
	);

	rvCoreTbMem mem_inst (
		.clk(clk), .rst_n(rst_n), .imemAddr(imemAddr), .imemData(imemData),
		.imemStall(imemStall), .dmemRead(dmemRead), .dmemWrite(dmemWrite),
		.dmemAddr(dmemAddr), .dmemWdata(dmemWdata), .dmemRdata(dmemRdata),
		.dmemStall(dmemStall)
	);

	function automatic string storeTest(input int idx);
		if (idx < 11) storeTest = "alu_forwarding";
		else if (idx < 13) storeTest = "load_use";
		else storeTest = "control_flow";
	endfunction

	task automatic reportMismatch(input string name, input logic [127:0] expVal,
			input logic [127:0] actVal);
		failCount++;
		$display("[ERROR] %s expected 0x%0h actual 0x%0h", name, expVal, actVal);
		$display("tests failed");
		$fatal(1);
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		failCount = 0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

	// Store acceptance means the whole pipeline advances
	assign storeAccepted = dmemWrite && !imemStall && !dmemStall;

	always_ff @(posedge clk) begin
		inResetQ <= !rst_n;
		stallQ <= rst_n && (imemStall || dmemStall);
		portQ <= {imemAddr, dmemAddr, dmemWdata, dmemRead, dmemWrite};
		if (!rst_n) storeIdx <= 0;
		else if (storeAccepted) storeIdx <= storeIdx + 1;
	end

	// ==========================================================================
	// Checks
	// ==========================================================================
	resetState: assert property (@(posedge clk)
		inResetQ |-> !dmemRead && !dmemWrite && imemAddr == RESET_PC_VAL[`XLEN-1:2])
		else reportMismatch("reset_state", {2'b00, RESET_PC_VAL[`XLEN-1:2]},
			{$sampled(dmemRead), $sampled(dmemWrite), $sampled(imemAddr)});

	storeCount: assert property (@(posedge clk) disable iff (!rst_n)
		storeAccepted |-> storeIdx < NUM_STORES)
		else reportMismatch("store_count", NUM_STORES, $sampled(storeIdx) + 1);

	storeAddr: assert property (@(posedge clk) disable iff (!rst_n)
		storeAccepted && storeIdx < NUM_STORES |-> dmemAddr == EXP_ADDR[storeIdx])
		else reportMismatch({storeTest($sampled(storeIdx)), "_addr"},
			EXP_ADDR[$sampled(storeIdx)], $sampled(dmemAddr));

	storeData: assert property (@(posedge clk) disable iff (!rst_n)
		storeAccepted && storeIdx < NUM_STORES |-> dmemWdata == EXP_DATA[storeIdx])
		else reportMismatch({storeTest($sampled(storeIdx)), "_data"},
			EXP_DATA[$sampled(storeIdx)], $sampled(dmemWdata));

	// Skipped-path stores sit at word addresses 50 to 54
	skippedStore: assert property (@(posedge clk) disable iff (!rst_n)
		storeAccepted |-> !(dmemAddr inside {[30'd50:30'd54]}))
		else reportMismatch("skipped_path_store", 0, $sampled(dmemAddr));

	portsHeld: assert property (@(posedge clk) disable iff (!rst_n)
		stallQ |-> {imemAddr, dmemAddr, dmemWdata, dmemRead, dmemWrite} == portQ)
		else reportMismatch("stall_hold", $sampled(portQ),
			{$sampled(imemAddr), $sampled(dmemAddr), $sampled(dmemWdata),
			$sampled(dmemRead), $sampled(dmemWrite)});

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired before the last expected store was seen");
		$display("tests failed");
		$fatal(1);
	end

	initial begin
		wait (rst_n === 1'b1 && storeIdx == NUM_STORES);
		repeat (2) @(posedge clk);
		if (failCount == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("tests failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

/* rvCoreTbMem.sv */
// Testbench memory model

`default_nettype none

`include "rvConsts.svh"

module rvCoreTbMem (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic [`XLEN-3:0]    imemAddr,
	output logic [`XLEN-1:0]         imemData,
	output logic                     imemStall,
	input  wire logic                dmemRead,
	input  wire logic                dmemWrite,
	input  wire logic [`XLEN-3:0]    dmemAddr,
	input  wire logic [`XLEN-1:0]    dmemWdata,
	output logic [`XLEN-1:0]         dmemRdata,
	output logic                     dmemStall
);

	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_LOAD = 7'b0000011;
	localparam logic [6:0] OP_JALR = 7'b1100111;

	logic [`XLEN-1:0] rom [64];
	logic [`XLEN-1:0] ram [256];
	logic [31:0] rngState;
	logic loadStallDone;

	// ==========================================================================
	// Instruction encoders
	// ==========================================================================
	function automatic logic [31:0] encR(input logic [6:0] f7, input int rs2, input int rs1,
			input logic [2:0] f3, input int rd);
		encR = {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] encI(input logic [11:0] imm, input int rs1,
			input logic [2:0] f3, input int rd, input logic [6:0] opc);
		encI = {imm, rs1[4:0], f3, rd[4:0], opc};
	endfunction

	function automatic logic [31:0] encS(input logic [11:0] imm, input int rs2, input int rs1);
		encS = {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] encB(input logic [12:0] imm, input int rs2, input int rs1,
			input logic [2:0] f3);
		encB = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] encJ(input logic [20:0] imm, input int rd);
		encJ = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		xorshift = s;
	endfunction

	// ==========================================================================
	// Program
	// ==========================================================================
	initial begin
		for (int i = 0; i < 64; i++) begin
			rom[i] = `NOP_INST;
		end
		for (int i = 0; i < 256; i++) begin
			ram[i] = 32'hC0DE_0000 ^ (i << 2); // Byte address in the low bits
		end
		rom[0] = encI(12'd100, 0, 3'b000, 1, OP_IMM);        // x1 = 100
		rom[1] = encI(12'hFF9, 0, 3'b000, 2, OP_IMM);        // x2 = -7
		rom[2] = encI(12'd3, 0, 3'b000, 7, OP_IMM);          // x7 = 3
		rom[3] = encR(7'h00, 2, 1, 3'b000, 3);               // add
		rom[4] = encS(12'd0, 3, 0);
		rom[5] = encR(7'h20, 2, 1, 3'b000, 4);               // sub
		rom[6] = encS(12'd4, 4, 0);
		rom[7] = encR(7'h00, 7, 1, 3'b001, 5);               // sll
		rom[8] = encS(12'd8, 5, 0);
		rom[9] = encR(7'h00, 1, 2, 3'b010, 6);               // slt
		rom[10] = encS(12'd12, 6, 0);
		rom[11] = encR(7'h00, 2, 1, 3'b100, 8);              // xor
		rom[12] = encS(12'd16, 8, 0);
		rom[13] = encR(7'h00, 7, 2, 3'b101, 9);              // srl
		rom[14] = encS(12'd20, 9, 0);
		rom[15] = encR(7'h20, 7, 2, 3'b101, 10);             // sra
		rom[16] = encS(12'd24, 10, 0);
		rom[17] = encR(7'h00, 2, 1, 3'b110, 11);             // or
		rom[18] = encS(12'd28, 11, 0);
		rom[19] = encR(7'h00, 2, 1, 3'b111, 12);             // and
		rom[20] = encS(12'd32, 12, 0);
		// Dependent immediate chain
		rom[21] = encI(12'd4, 1, 3'b001, 13, OP_IMM);        // slli
		rom[22] = encI(12'h00F, 13, 3'b100, 13, OP_IMM);     // xori
		rom[23] = encI(12'h100, 13, 3'b110, 13, OP_IMM);     // ori
		rom[24] = encI(12'h1F0, 13, 3'b111, 13, OP_IMM);     // andi
		rom[25] = encI(12'h401, 2, 3'b101, 14, OP_IMM);      // srai
		rom[26] = encI(12'hFFD, 14, 3'b010, 15, OP_IMM);     // slti
		rom[27] = encR(7'h00, 15, 13, 3'b000, 16);
		rom[28] = encS(12'd36, 16, 0);
		rom[29] = encS(12'd40, 14, 0);
		// Load-use pairs
		rom[30] = encI(12'h100, 0, 3'b010, 17, OP_LOAD);
		rom[31] = encI(12'd7, 17, 3'b000, 18, OP_IMM);
		rom[32] = encS(12'd44, 18, 0);
		rom[33] = encI(12'd0, 0, 3'b010, 19, OP_LOAD);
		rom[34] = encR(7'h00, 1, 19, 3'b000, 20);
		rom[35] = encS(12'd48, 20, 0);
		// Control flow, stores at 37, 39, 45, 49 and 53 are skipped
		rom[36] = encB(13'd8, 1, 1, 3'b000);                // beq taken
		rom[37] = encS(12'd200, 1, 0);
		rom[38] = encB(13'd8, 2, 1, 3'b001);                // bne taken
		rom[39] = encS(12'd204, 1, 0);
		rom[40] = encB(13'd8, 2, 1, 3'b000);                // beq not taken
		rom[41] = encS(12'd52, 7, 0);
		rom[42] = encB(13'd8, 1, 1, 3'b001);                // bne not taken
		rom[43] = encS(12'd56, 7, 0);
		rom[44] = encJ(21'd8, 21);
		rom[45] = encS(12'd208, 1, 0);
		rom[46] = encS(12'd60, 21, 0);                       // Link value
		rom[47] = encI(12'd196, 0, 3'b000, 22, OP_IMM);
		rom[48] = encI(12'd4, 22, 3'b000, 23, OP_JALR);     // Base from EX
		rom[49] = encS(12'd212, 1, 0);
		rom[50] = encS(12'd64, 23, 0);
		rom[51] = encI(12'd3, 0, 3'b000, 24, OP_IMM);
		rom[52] = encB(13'd8, 7, 24, 3'b000);               // Operand from EX
		rom[53] = encS(12'd216, 1, 0);
		rom[54] = encS(12'd68, 24, 0);
		rom[55] = encJ(21'd0, 0);                            // Park here
	end

	assign imemData = rom[imemAddr[5:0]];
	assign dmemRdata = ram[dmemAddr[7:0]];

	// Stall lines change on the falling edge
	initial begin
		imemStall = 1'b0;
		dmemStall = 1'b0;
		rngState = 32'd89;
		loadStallDone = 1'b0;
		forever begin
			@(negedge clk);
			if (!rst_n) begin
				imemStall = 1'b0;
				dmemStall = 1'b0;
			end else begin
				rngState = xorshift(rngState);
				imemStall = rngState[2:0] == 3'd0;
				dmemStall = rngState[5:3] == 3'd0;
				if (dmemRead && !loadStallDone) begin // First load always waits
					dmemStall = 1'b1;
					loadStallDone = 1'b1;
				end
			end
		end
	end

	always @(posedge clk) begin
		if (dmemWrite && !imemStall && !dmemStall) begin
			ram[dmemAddr[7:0]] <= dmemWdata;
		end
	end

endmodule

`default_nettype wire

/* rvDecode.sv */
// Instruction decoder

`default_nettype none

`include "rvConsts.svh"

module rvDecode
	import rvPkg::*;
(
	input  wire logic [`XLEN-1:0]       inst,
	output logic                        isJal,
	output logic                        isJalr,
	output logic                        isBeq,
	output logic                        isBne,
	output logic                        memRead,
	output logic                        memWrite,
	output logic                        memToReg,
	output logic                        aluSrc,
	output logic                        regWrite,
	output aluOpT                       aluOp,
	output logic [`XLEN-1:0]            immediate,
	output logic [`REG_ADDR_W-1:0]      rs1,
	output logic [`REG_ADDR_W-1:0]      rs2,
	output logic [`REG_ADDR_W-1:0]      rd
);

	opcodeT opcode;
	logic [2:0] funct3;
	logic valid;
	logic [`XLEN-1:0] immI, immShamt, immS, immB, immJ;

	// funct7[5] only splits add/sub for register operands
	function automatic aluOpT aluSelect(input logic [2:0] f3, input logic f7b5,
			input logic isReg);
		case (f3)
			3'b000:  aluSelect = (isReg && f7b5) ? AluSub : AluAdd;
			3'b001:  aluSelect = AluSll;
			3'b010:  aluSelect = AluSlt;
			3'b100:  aluSelect = AluXor;
			3'b101:  aluSelect = f7b5 ? AluSra : AluSrl;
			3'b110:  aluSelect = AluOr;
			3'b111:  aluSelect = AluAnd;
			default: aluSelect = AluAdd;
		endcase
	endfunction

	assign opcode = opcodeT'(inst[6:2]);
	assign funct3 = inst[14:12];
	assign valid = inst[1:0] == 2'b11; // Compressed forms unsupported
	assign rs1 = inst[19:15];
	assign rs2 = inst[24:20];
	assign rd = inst[11:7];

	// Immediate formats
	assign immI = {{20{inst[31]}}, inst[31:20]};
	assign immShamt = {{(`XLEN-5){1'b0}}, inst[24:20]};
	assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		isJal = 1'b0;
		isJalr = 1'b0;
		isBeq = 1'b0;
		isBne = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		aluSrc = 1'b0;
		regWrite = 1'b0;
		aluOp = AluAdd; // Address and link paths all add
		immediate = '0;
		if (valid) begin
			case (opcode)
				OpReg: begin
					regWrite = 1'b1;
					aluOp = aluSelect(funct3, inst[30], 1'b1);
				end
				OpImm: begin
					regWrite = 1'b1;
					aluSrc = 1'b1;
					aluOp = aluSelect(funct3, inst[30], 1'b0);
					immediate = (funct3[1:0] == 2'b01) ? immShamt : immI;
				end
				OpLoad: begin
					memRead = 1'b1;
					memToReg = 1'b1;
					regWrite = 1'b1;
					aluSrc = 1'b1;
					immediate = immI;
				end
				OpStore: begin
					memWrite = 1'b1;
					aluSrc = 1'b1;
					immediate = immS;
				end
				OpBranch: begin
					isBeq = funct3 == 3'b000;
					isBne = funct3 == 3'b001;
					immediate = immB;
				end
				OpJal: begin
					isJal = 1'b1;
					regWrite = 1'b1;
					immediate = immJ;
				end
				OpJalr: begin
					isJalr = 1'b1;
					regWrite = 1'b1;
					immediate = immI;
				end
				default: ; // Unknown opcode stays inactive
			endcase
		end
	end

endmodule

`default_nettype wire

/* rvFetch.sv */
// Fetch stage and IF/ID register

`default_nettype none

`include "rvConsts.svh"

module rvFetch
	import rvPkg::*;
(
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                memStall,
	input  wire logic                hazardStall,
	input  wire logic                flushIfId,
	input  wire logic [`XLEN-1:0]    imemData,
	input  wire logic                isJal,
	input  wire logic                isJalr,
	input  wire logic                isBeq,
	input  wire logic                isBne,
	input  wire logic [`XLEN-1:0]    immediate,
	input  wire logic [`XLEN-1:0]    branchRs1,
	input  wire logic [`XLEN-1:0]    branchRs2,
	output logic [`XLEN-3:0]         imemAddr,
	output logic [`XLEN-1:0]         idPc,
	output logic [`XLEN-1:0]         idInst,
	output logic                     branchTaken
);

	localparam logic [`XLEN-1:0] PC_STEP = 4;

	logic [`XLEN-1:0] pc, pcNext, jalrTarget, idTarget;
	logic holdAll;

	assign holdAll = memStall || hazardStall;
	assign imemAddr = pc[`XLEN-1:2]; // Word address

	// Predicted not taken, resolved in ID
	assign branchTaken = (isBeq && branchRs1 == branchRs2) || (isBne && branchRs1 != branchRs2);
	assign jalrTarget = (branchRs1 + immediate) & {{(`XLEN-1){1'b1}}, 1'b0};
	assign idTarget = idPc + immediate;

	always_comb begin
		if (holdAll) pcNext = pc;
		else if (isJalr) pcNext = jalrTarget;
		else if (isJal || branchTaken) pcNext = idTarget;
		else pcNext = pc + PC_STEP;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) pc <= `RESET_PC;
		else pc <= pcNext;
	end

	// IF/ID
	always_ff @(posedge clk) begin
		if (!rst_n) idInst <= `NOP_INST;
		else if (!holdAll) idInst <= flushIfId ? `NOP_INST : imemData;
	end

	always_ff @(posedge clk) begin
		if (!holdAll) idPc <= pc;
	end

	// Jump and branch targets stay word aligned
	pcAligned: assert property (@(posedge clk) disable iff (!rst_n)
		pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* rvHazard.sv */
// Forwarding and interlock unit

`default_nettype none

`include "rvConsts.svh"

module rvHazard
	import rvPkg::*;
(
	input  wire logic [`REG_ADDR_W-1:0]  idRs1,
	input  wire logic [`REG_ADDR_W-1:0]  idRs2,
	input  wire logic                    idIsJalr,
	input  wire logic                    idIsBranch,
	input  wire logic                    branchTaken,
	input  wire logic                    idIsJal,
	input  wire logic [`XLEN-1:0]        idRs1Data,
	input  wire logic [`XLEN-1:0]        idRs2Data,
	input  wire logic [`REG_ADDR_W-1:0]  exRd,
	input  wire logic                    exMemRead,
	input  wire logic                    exRegWrite,
	input  wire logic [`REG_ADDR_W-1:0]  exRs1,
	input  wire logic [`REG_ADDR_W-1:0]  exRs2,
	input  wire logic [`REG_ADDR_W-1:0]  memRd,
	input  wire logic                    memRegWrite,
	input  wire logic [`XLEN-1:0]        memResult,
	input  wire logic [`REG_ADDR_W-1:0]  wbRd,
	input  wire logic                    wbRegWrite,
	input  wire logic [`XLEN-1:0]        wbData,
	output logic                         hazardStall,
	output logic                         flushIfId,
	output fwdSelT                       fwdA,
	output fwdSelT                       fwdB,
	output logic [`XLEN-1:0]             branchRs1,
	output logic [`XLEN-1:0]             branchRs2
);

	logic memLive, wbLive;
	logic exHit1, exHit2;
	logic loadUse, jalrUse, branchUse;

	// MEM wins over WB
	function automatic fwdSelT exSelect(input logic [`REG_ADDR_W-1:0] src);
		if (memLive && memRd == src) exSelect = FwdMem;
		else if (wbLive && wbRd == src) exSelect = FwdWb;
		else exSelect = FwdNone;
	endfunction

	function automatic logic [`XLEN-1:0] idOperand(input logic [`REG_ADDR_W-1:0] src,
			input logic [`XLEN-1:0] regValue);
		if (memLive && memRd == src) idOperand = memResult;
		else if (wbLive && wbRd == src) idOperand = wbData;
		else idOperand = regValue;
	endfunction

	assign memLive = memRegWrite && memRd != '0;
	assign wbLive = wbRegWrite && wbRd != '0;

	// ==========================================================================
	// EX operand selects and ID compare operands
	// ==========================================================================
	assign fwdA = exSelect(exRs1);
	assign fwdB = exSelect(exRs2);
	assign branchRs1 = idOperand(idRs1, idRs1Data);
	assign branchRs2 = idOperand(idRs2, idRs2Data);

	// ==========================================================================
	// Interlocks against the instruction in EX
	// ==========================================================================
	// jal carries immediate bits in the rs fields
	assign exHit1 = exRegWrite && exRd != '0 && exRd == idRs1 && !idIsJal;
	assign exHit2 = exRegWrite && exRd != '0 && exRd == idRs2 && !idIsJal;

	assign loadUse = exMemRead && (exHit1 || exHit2);
	assign jalrUse = idIsJalr && exHit1; // Base not yet computed
	assign branchUse = idIsBranch && (exHit1 || exHit2);

	assign hazardStall = loadUse || jalrUse || branchUse;

	// Jumps and branches flush once their own interlock clears
	assign flushIfId = idIsJal || (idIsJalr && !jalrUse && !loadUse)
		|| (branchTaken && !branchUse);

	stallFlushExclusive: assert final (!(hazardStall && flushIfId))
		else $error("hazard stall and IF/ID flush raised together");

endmodule

`default_nettype wire

/* rvPkg.sv */
// RV32I pipeline types

`default_nettype none

`include "rvConsts.svh"

package rvPkg;

	// Field widths of the control bundle
	localparam int OPCODE_W = 5;
	localparam int ALU_OP_W = 4;
	localparam int FWD_SEL_W = 2;

	// Major opcode, bits [6:2] of the instruction
	typedef enum logic [OPCODE_W-1:0] {
		OpLoad   = 5'b00000,
		OpImm    = 5'b00100,
		OpStore  = 5'b01000,
		OpReg    = 5'b01100,
		OpBranch = 5'b11000,
		OpJalr   = 5'b11001,
		OpJal    = 5'b11011
	} opcodeT;

	// Encoded as {funct7[5], funct3}
	typedef enum logic [ALU_OP_W-1:0] {
		AluAdd = 4'b0000,
		AluSll = 4'b0001,
		AluSlt = 4'b0010,
		AluXor = 4'b0100,
		AluSrl = 4'b0101,
		AluOr  = 4'b0110,
		AluAnd = 4'b0111,
		AluSub = 4'b1000,
		AluSra = 4'b1101
	} aluOpT;

	typedef enum logic [FWD_SEL_W-1:0] {FwdNone, FwdMem, FwdWb} fwdSelT;

endpackage

`default_nettype wire

/* rvRegFile.sv */
// Integer register file

`default_nettype none

`include "rvConsts.svh"

module rvRegFile (
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  wire logic [`REG_ADDR_W-1:0]  rs1,
	input  wire logic [`REG_ADDR_W-1:0]  rs2,
	input  wire logic [`REG_ADDR_W-1:0]  wrAddr,
	input  wire logic [`XLEN-1:0]        wrData,
	input  wire logic                    wrEn,
	output logic [`XLEN-1:0]             rs1Data,
	output logic [`XLEN-1:0]             rs2Data
);

	logic [`XLEN-1:0] regs [`NUM_REGS];
	logic wrLive;

	assign wrLive = wrEn && wrAddr != '0; // x0 is never written

	// Same-cycle write-back is visible to the ID read
	assign rs1Data = (rs1 == '0) ? '0 : (wrLive && wrAddr == rs1) ? wrData : regs[rs1];
	assign rs2Data = (rs2 == '0) ? '0 : (wrLive && wrAddr == rs2) ? wrData : regs[rs2];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wrLive) begin
			regs[wrAddr] <= wrData;
		end
	end

endmodule

`default_nettype wire
